//--- include/sad_defines.svh
`ifndef SAD_DEFINES_SVH
`define SAD_DEFINES_SVH

// ========================================
// Activation and block geometry
// ========================================

// One activation value
`define SAD_DATA_WIDTH 8

// Activations per dense block, also the flag word width
`define SAD_BLOCK_DEPTH 32

// Dense block width, all places side by side
`define SAD_BLOCK_WIDTH (`SAD_DATA_WIDTH * `SAD_BLOCK_DEPTH)

// ========================================
// Global buffer geometry
// ========================================

// Buffer address, 256 words
`define SAD_ADDR_WIDTH 8

// Words per global buffer
`define SAD_GBUF_DEPTH (1 << `SAD_ADDR_WIDTH)

// Non-zero count, 0 up to BLOCK_DEPTH inclusive
`define SAD_CNT_WIDTH 6

`endif

//--- design/sad_pkg.sv
`default_nettype none

package sad_pkg;

    `include "sad_defines.svh"

    // Single compressed activation
    typedef logic [`SAD_DATA_WIDTH-1:0] act_t;

    // Non-zero bitmap of one block
    typedef logic [`SAD_BLOCK_DEPTH-1:0] flag_t;

    // Read address into either buffer
    typedef logic [`SAD_ADDR_WIDTH-1:0] addr_t;

    // Popcount of a flag word
    typedef logic [`SAD_CNT_WIDTH-1:0] cnt_t;

    // Dense block, place i at bits [i*8 +: 8]
    typedef logic [`SAD_BLOCK_WIDTH-1:0] block_t;

    // Distributor control sequence
    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        PACK,
        HOLD
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- design/sad_gbuf_if.sv
`timescale 1ns/100ps
`default_nettype none

// Read port of one global buffer
interface sad_gbuf_if
    import sad_pkg::*;
#(
    parameter int WIDTH = 8
) ();

    // Read strobe and address, from the reader
    logic             en_rd;
    addr_t            addr_rd;
    // Registered read data, one cycle after en_rd
    logic [WIDTH-1:0] dat_rd;
    // Word at addr_rd has been written
    logic             val;

    modport reader (output en_rd, output addr_rd, input dat_rd, input val);

    modport buffer (input en_rd, input addr_rd, output dat_rd, output val);

endinterface

`default_nettype wire

//--- design/sad_gbuf.sv
`timescale 1ns/100ps
`default_nettype none

`include "sad_defines.svh"

module sad_gbuf #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst_n,
    // Sequential write side
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_dat,
    // Read side
    sad_gbuf_if.buffer       rd
);

    localparam int unsigned DEPTH = `SAD_GBUF_DEPTH;

    // ========================================
    // Storage and write pointer
    // ========================================

    logic [WIDTH-1:0]          mem [DEPTH];

    // One extra bit so a full buffer reads as 256
    logic [`SAD_ADDR_WIDTH:0]  wr_cnt;
    logic                      full;
    logic                      wr_ok;

    assign full  = wr_cnt[`SAD_ADDR_WIDTH];
    // Writes past the last word are dropped
    assign wr_ok = wr_en && !full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else if (wr_ok) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_cnt[`SAD_ADDR_WIDTH-1:0]] <= wr_dat;
        end
    end

    // ========================================
    // Read port
    // ========================================

    // Data for addr_rd is present once the writer has passed it
    assign rd.val = wr_cnt > {1'b0, rd.addr_rd};

    // Registered read, data one cycle after en_rd
    always_ff @(posedge clk) begin
        if (rd.en_rd) begin
            rd.dat_rd <= mem[rd.addr_rd];
        end
    end

endmodule

`default_nettype wire

//--- design/act_dist_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module act_dist_ctrl
    import sad_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    // Request for the next dense block
    input  logic fetch,
    // Flag buffer has the next word
    input  logic flag_val,
    // Packer finished the block
    input  logic done,
    // Single flag read strobe
    output logic flag_rd,
    // Block, flags stable for the consumer
    output logic rdy
);

    // ========================================
    // State register
    // ========================================

    ctrl_state_t state;
    ctrl_state_t next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ========================================
    // Next state
    // ========================================

    always_comb begin
        next_state = state;
        unique case (state)
            // Nothing fetched yet
            IDLE: begin
                if (fetch) begin
                    next_state = CHECK;
                end
            end
            // Wait for the flag word of the next block
            CHECK: begin
                if (flag_val) begin
                    next_state = PACK;
                end
            end
            // Flag read, popcount and scatter in flight
            // Fetch pulses here are dropped
            PACK: begin
                if (done) begin
                    next_state = HOLD;
                end
            end
            // Block presented until the next request
            HOLD: begin
                if (fetch) begin
                    next_state = CHECK;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // ========================================
    // Outputs
    // ========================================

    // Only the CHECK to PACK step reads a flag word,
    // so exactly one read per block
    assign flag_rd = (state == CHECK) && flag_val;

    // Ready is the HOLD level itself
    assign rdy = (state == HOLD);

endmodule

`default_nettype wire

//--- design/flag_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module flag_fetch
    import sad_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    // One read per block from the controller
    input  logic         flag_rd,
    sad_gbuf_if.reader   flag_bus,
    // Flag buffer valid, passed to the controller
    output logic         flag_val,
    // Packer kick, with the count and bitmap
    output logic         start,
    output cnt_t         cnt,
    output flag_t        mask
);

    // Number of set bits in a flag word
    function automatic cnt_t popcount(input flag_t word);
        cnt_t sum;
        sum = '0;
        for (int i = 0; i < $bits(flag_t); i++) begin
            sum = sum + cnt_t'(word[i]);
        end
        return sum;
    endfunction

    addr_t flag_addr;
    // Read strobe delayed to line up with dat_rd
    logic  rd_d;

    assign flag_bus.en_rd   = flag_rd;
    assign flag_bus.addr_rd = flag_addr;
    assign flag_val         = flag_bus.val;

    // Next flag word on every read, never rewound
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_addr <= '0;
        end else if (flag_rd) begin
            flag_addr <= flag_addr + addr_t'(1);
        end
    end

    // Capture the word and its count, start follows
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_d  <= 1'b0;
            start <= 1'b0;
            cnt   <= '0;
            mask  <= '0;
        end else begin
            rd_d  <= flag_rd;
            start <= rd_d;
            if (rd_d) begin
                mask <= flag_bus.dat_rd;
                cnt  <= popcount(flag_bus.dat_rd);
            end
        end
    end

endmodule

`default_nettype wire

//--- design/act_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "sad_defines.svh"

module act_packer
    import sad_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    // Block kick from flag_fetch
    input  logic         start,
    input  cnt_t         cnt,
    input  flag_t        mask,
    sad_gbuf_if.reader   act_bus,
    // Dense block out
    output block_t       blk,
    output logic         done
);

    // ========================================
    // Read side
    // ========================================

    addr_t act_addr;
    // Reads still to issue for this block
    cnt_t  rem;
    // Read issued last cycle, dat_rd is live
    logic  val_dat;

    // Only read words that exist in the buffer
    assign act_bus.en_rd   = (rem != '0) && act_bus.val;
    assign act_bus.addr_rd = act_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_addr <= '0;
            rem      <= '0;
            val_dat  <= 1'b0;
            done     <= 1'b0;
        end else begin
            val_dat <= act_bus.en_rd;
            // Zero count bypasses, else last read lands next cycle
            done    <= (start && (cnt == '0)) ||
                       (act_bus.en_rd && (rem == cnt_t'(1)));
            if (act_bus.en_rd) begin
                act_addr <= act_addr + addr_t'(1);
            end
            if (start) begin
                rem <= cnt;
            end else if (act_bus.en_rd) begin
                rem <= rem - cnt_t'(1);
            end
        end
    end

    // ========================================
    // Scatter side
    // ========================================

    // Flagged places not yet filled
    flag_t open_mask;
    // Lowest open place, one-hot
    flag_t low_bit;

    assign low_bit = open_mask & (~open_mask + flag_t'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            open_mask <= '0;
            blk       <= '0;
        end else if (start) begin
            // Unflagged places stay zero
            open_mask <= mask;
            blk       <= '0;
        end else if (val_dat) begin
            open_mask <= open_mask & ~low_bit;
            for (int i = 0; i < `SAD_BLOCK_DEPTH; i++) begin
                if (low_bit[i]) begin
                    blk[i*`SAD_DATA_WIDTH +: `SAD_DATA_WIDTH] <= act_bus.dat_rd;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sparse_act_dist.sv
`timescale 1ns/100ps
`default_nettype none

`include "sad_defines.svh"

module sparse_act_dist
    import sad_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    // Block request
    input  logic   fetch,
    // Compressed activation writes
    input  logic   act_wr_en,
    input  act_t   act_wr_dat,
    // Flag word writes
    input  logic   flag_wr_en,
    input  flag_t  flag_wr_dat,
    // Presented block
    output logic   rdy,
    output flag_t  flg,
    output block_t blk
);

    // ========================================
    // Buffers
    // ========================================

    sad_gbuf_if #(.WIDTH(`SAD_BLOCK_DEPTH)) flag_bus ();
    sad_gbuf_if #(.WIDTH(`SAD_DATA_WIDTH))  act_bus ();

    sad_gbuf #(.WIDTH(`SAD_BLOCK_DEPTH)) flag_gbuf_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (flag_wr_en),
        .wr_dat (flag_wr_dat),
        .rd     (flag_bus.buffer)
    );

    sad_gbuf #(.WIDTH(`SAD_DATA_WIDTH)) act_gbuf_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (act_wr_en),
        .wr_dat (act_wr_dat),
        .rd     (act_bus.buffer)
    );

    // ========================================
    // Control and datapath
    // ========================================

    logic flag_rd;
    logic flag_val;
    logic start;
    logic done;
    cnt_t cnt;

    act_dist_ctrl ctrl_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch    (fetch),
        .flag_val (flag_val),
        .done     (done),
        .flag_rd  (flag_rd),
        .rdy      (rdy)
    );

    // Flag register doubles as the flg output
    flag_fetch flag_fetch_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .flag_rd  (flag_rd),
        .flag_bus (flag_bus.reader),
        .flag_val (flag_val),
        .start    (start),
        .cnt      (cnt),
        .mask     (flg)
    );

    act_packer act_packer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .cnt     (cnt),
        .mask    (flg),
        .act_bus (act_bus.reader),
        .blk     (blk),
        .done    (done)
    );

endmodule

`default_nettype wire

//--- dv/sad_properties.sv
`timescale 1ns/100ps
`default_nettype none

module sad_properties
    import sad_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        fetch,
    input logic        flag_rd,
    input logic        rdy,
    input logic        done,
    input ctrl_state_t state
);

    // One flag read per block, never a burst
    flag_rd_single: assert property (@(posedge clk) disable iff (!rst_n)
        flag_rd |=> !flag_rd)
        else $error("flag_rd high for more than one cycle");

    // A new request releases the held block at once
    rdy_falls_on_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (state == HOLD) && fetch |=> !rdy)
        else $error("rdy still high the cycle after a fetch in HOLD");

    // Packer completion only while a block is in flight
    done_only_in_pack: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (state == PACK))
        else $error("done high outside PACK");

endmodule

bind act_dist_ctrl sad_properties props_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .fetch   (fetch),
    .flag_rd (flag_rd),
    .rdy     (rdy),
    .done    (done),
    .state   (state)
);

`default_nettype wire

//--- dv/sad_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "sad_defines.svh"

module sad_tb
    import sad_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 500;

    logic   clk;
    logic   rst_n;
    logic   fetch;
    logic   act_wr_en;
    act_t   act_wr_dat;
    logic   flag_wr_en;
    flag_t  flag_wr_dat;
    logic   rdy;
    flag_t  flg;
    block_t blk;

    // Model state, everything written and not yet consumed
    flag_t       flag_q[$];
    act_t        act_q[$];
    int          errors;
    int          checks;
    int          timeouts;

    sparse_act_dist dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch       (fetch),
        .act_wr_en   (act_wr_en),
        .act_wr_dat  (act_wr_dat),
        .flag_wr_en  (flag_wr_en),
        .flag_wr_dat (flag_wr_dat),
        .rdy         (rdy),
        .flg         (flg),
        .blk         (blk)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // ========================================
    // Closing report
    // ========================================

    task automatic report_and_finish();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // ========================================
    // Buffer writes
    // ========================================

    task automatic write_flag(input flag_t f);
        flag_q.push_back(f);
        @(posedge clk);
        flag_wr_en  <= 1'b1;
        flag_wr_dat <= f;
        @(posedge clk);
        flag_wr_en  <= 1'b0;
    endtask

    // n random non-zero activations, back to back
    task automatic write_acts(input int n);
        act_t a;
        for (int i = 0; i < n; i++) begin
            a = act_t'($urandom_range(255, 1));
            act_q.push_back(a);
            @(posedge clk);
            act_wr_en  <= 1'b1;
            act_wr_dat <= a;
        end
        @(posedge clk);
        act_wr_en <= 1'b0;
    endtask

    task automatic write_block(input flag_t f);
        write_flag(f);
        write_acts($countones(f));
    endtask

    // ========================================
    // Fetch, wait and compare
    // ========================================

    // One-cycle fetch pulse
    task automatic send_fetch();
        @(posedge clk);
        fetch <= 1'b1;
        @(posedge clk);
        fetch <= 1'b0;
    endtask

    task automatic wait_rdy(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rdy && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!rdy) begin
            $display("Timeout: rdy did not rise within %0d cycles during %s",
                     TIMEOUT_CYCLES, what);
            timeouts++;
        end
    endtask

    // Model: i-th activation goes to the i-th set flag bit
    task automatic check_block(input string what);
        flag_t  exp_flg;
        block_t exp_blk;
        exp_blk = '0;
        if (flag_q.size() == 0) begin
            $display("Model has no flag word left for %s", what);
            errors++;
            return;
        end
        exp_flg = flag_q.pop_front();
        for (int i = 0; i < `SAD_BLOCK_DEPTH; i++) begin
            if (exp_flg[i]) begin
                if (act_q.size() == 0) begin
                    $display("Model ran out of activations for %s", what);
                    errors++;
                end else begin
                    exp_blk[i*`SAD_DATA_WIDTH +: `SAD_DATA_WIDTH] = act_q.pop_front();
                end
            end
        end
        checks++;
        if (flg !== exp_flg) begin
            $display("** Error at %0t: %s flg %h, expected %h", $time, what, flg, exp_flg);
            errors++;
        end
        if (blk !== exp_blk) begin
            $display("** Error at %0t: %s blk %h, expected %h", $time, what, blk, exp_blk);
            errors++;
        end
    endtask

    task automatic fetch_and_check(input string what);
        send_fetch();
        wait_rdy(what);
        check_block(what);
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial begin
        void'($urandom(32'hb3a0));
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        clk         = 1'b0;
        rst_n       = 1'b0;
        fetch       = 1'b0;
        act_wr_en   = 1'b0;
        act_wr_dat  = '0;
        flag_wr_en  = 1'b0;
        flag_wr_dat = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values
        @(negedge clk);
        checks++;
        if (rdy !== 1'b0 || flg !== '0 || blk !== '0) begin
            $display("** Error at %0t: after reset rdy %b flg %h blk %h, expected all zero",
                     $time, rdy, flg, blk);
            errors++;
        end

        // Sparse, zero and full flag words, all written ahead
        for (int b = 0; b < 6; b++) begin
            write_block(flag_t'($urandom & $urandom & $urandom));
        end
        write_block('0);
        write_block(flag_t'($urandom & $urandom & $urandom) | flag_t'(32'h8000_0001));
        write_block('1);
        write_block(flag_t'($urandom & $urandom));
        for (int b = 0; b < 10; b++) begin
            fetch_and_check("prewritten block");
        end

        // Second fetch pulse while the block is in flight
        write_block(flag_t'($urandom & $urandom) | flag_t'(32'h0001_0000));
        send_fetch();
        send_fetch();
        wait_rdy("double fetch");
        check_block("double fetch");

        // Flag word present, activations held back
        write_flag(flag_t'($urandom & $urandom) | flag_t'(32'h0000_0100));
        send_fetch();
        for (int c = 0; c < 60; c++) begin
            if (c % 15 == 0) begin
                send_fetch();
            end
            @(negedge clk);
            if (rdy !== 1'b0) begin
                $display("** Error at %0t: rdy high before activations were written",
                         $time);
                errors++;
            end
        end
        write_acts($countones(flag_q[0]));
        wait_rdy("late activations");
        check_block("late activations");

        // Order still intact afterwards
        write_block(flag_t'($urandom & $urandom & $urandom));
        fetch_and_check("block after stall");

        if (flag_q.size() != 0 || act_q.size() != 0) begin
            $display("Model still holds %0d flag words and %0d activations at the end",
                     flag_q.size(), act_q.size());
            errors++;
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

//--- sparse_act_dist.f
+incdir+include
design/sad_pkg.sv
design/sad_gbuf_if.sv
design/sad_gbuf.sv
design/act_dist_ctrl.sv
design/flag_fetch.sv
design/act_packer.sv
design/sparse_act_dist.sv
dv/sad_properties.sv
dv/sad_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = sad_tb
FILELIST = sparse_act_dist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
